//--- common/eeprom_pkg.sv
package eeprom_pkg;

    // 2 Kbyte part, the top three address bits travel in the control byte
    localparam int ADDR_W = 11;

    localparam logic [3:0] DEV_CODE = 4'b1010; // two-wire EEPROM device type

    // host request, captured when wr or rd is accepted
    typedef struct packed {
        logic              is_wr;  // 1 write, 0 read
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

endpackage

//--- common/i2c_pkg.sv
package i2c_pkg;

    // one-cycle strobes, one per quarter of the SCL period
    typedef struct packed {
        logic scl_fall;  // SCL goes low
        logic low_mid;   // data may change here
        logic scl_rise;  // SCL goes high
        logic high_mid;  // sample point, also start and stop
    } i2c_phase_t;

    // request of one block on the open-drain SDA line
    typedef struct packed {
        logic sda_low; // pull SDA low
        logic sda_en;  // block owns SDA
    } i2c_drive_t;

endpackage

//--- hdl/scl_gen.sv
`timescale 1ns/1ps
module scl_gen
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 2 // cycles per quarter, 2 or more
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl_run,
    output logic       scl,
    output i2c_phase_t phase
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic [1:0]       quarter; // 0 fall, 1 low_mid, 2 rise, 3 high_mid
    logic [1:0]       next_q;

    assign next_q = quarter + 2'd1;

    always_ff @(posedge CLK)
    begin
        if (RESET || !scl_run)
        begin
            div_cnt <= '0;
            quarter <= 2'd3; // parked in the high half
            scl     <= 1'b1;
            phase   <= '0;
        end
        else
        begin
            phase <= '0;
            if (div_cnt == CNT_W'(CLK_DIV - 1))
            begin
                div_cnt        <= '0;
                quarter        <= next_q;
                phase.scl_fall <= (next_q == 2'd0);
                phase.low_mid  <= (next_q == 2'd1);
                phase.scl_rise <= (next_q == 2'd2);
                phase.high_mid <= (next_q == 2'd3);
                if (next_q == 2'd0)
                    scl <= 1'b0;
                else if (next_q == 2'd2)
                    scl <= 1'b1;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

//--- hdl/byte_tx.sv
`timescale 1ns/1ps
module byte_tx
    import i2c_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  i2c_phase_t phase,
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    input  logic       sda_in,
    output i2c_drive_t tx_drive,
    output logic       tx_done,
    output logic       tx_nack
);

    logic [7:0] shift_reg;
    logic [3:0] bit_cnt; // low_mid strobes seen, 9 per byte
    logic       active;

    always_ff @(posedge CLK)
    begin
        if (tx_load)
            shift_reg <= tx_byte;
        else if (active && phase.low_mid && bit_cnt < 4'd8)
            shift_reg <= {shift_reg[6:0], 1'b0}; // msb first
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            bit_cnt  <= 4'd0;
            tx_drive <= '0;
            tx_done  <= 1'b0;
            tx_nack  <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (tx_load)
            begin
                active   <= 1'b1;
                bit_cnt  <= 4'd0;
                tx_drive <= '{sda_low: 1'b0, sda_en: 1'b1};
            end
            else if (active && phase.low_mid)
            begin
                // open drain: pull for zeros, release for ones and the ack slot
                tx_drive.sda_low <= (bit_cnt < 4'd8) ? ~shift_reg[7] : 1'b0;
                bit_cnt          <= bit_cnt + 4'd1;
            end
            else if (active && phase.high_mid && bit_cnt == 4'd9)
            begin
                active   <= 1'b0;
                tx_drive <= '0;
                tx_done  <= 1'b1;
                tx_nack  <= sda_in; // high means slave did not ack
            end
        end
    end

endmodule

//--- hdl/byte_rx.sv
`timescale 1ns/1ps
module byte_rx
    import i2c_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  i2c_phase_t phase,
    input  logic       rx_start,
    input  logic       rx_last,
    input  logic       sda_in,
    output i2c_drive_t rx_drive,
    output logic       rx_done,
    output logic [7:0] rx_byte
);

    logic [7:0] shift_reg;
    logic [3:0] bit_cnt; // data bits sampled
    logic       active;
    logic       last_q;

    assign rx_byte = shift_reg;

    always_ff @(posedge CLK)
    begin
        if (active && phase.high_mid && bit_cnt < 4'd8)
            shift_reg <= {shift_reg[6:0], sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            bit_cnt  <= 4'd0;
            last_q   <= 1'b0;
            rx_drive <= '0;
            rx_done  <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            if (rx_start)
            begin
                active  <= 1'b1;
                bit_cnt <= 4'd0;
                last_q  <= rx_last;
            end
            else if (active && phase.high_mid)
            begin
                if (bit_cnt == 4'd8)
                begin
                    active  <= 1'b0; // ack slot sampled by the slave
                    rx_done <= 1'b1;
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else if (active && phase.low_mid && bit_cnt == 4'd8)
                rx_drive <= '{sda_low: ~last_q, sda_en: 1'b1}; // nack on last byte
            else if (!active && phase.scl_fall)
                rx_drive <= '0; // hand SDA back only with SCL low
        end
    end

endmodule

//--- eeprom_ctrl/eeprom_seq.sv
`timescale 1ns/1ps
module eeprom_seq
    import eeprom_pkg::*;
    import i2c_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    input  i2c_phase_t        phase,
    input  logic              tx_done,
    input  logic              tx_nack,
    input  logic              rx_done,
    input  logic [7:0]        rx_byte,
    output logic              scl_run,
    output logic              tx_load,
    output logic [7:0]        tx_byte,
    output logic              rx_start,
    output logic              rx_last,
    output i2c_drive_t        seq_drive,
    output logic [7:0]        rdata,
    output logic              ack,
    output logic              nack_err,
    output logic              busy
);

    // one-hot main states
    localparam logic [9:0] IDLE       = 10'b00_0000_0001;
    localparam logic [9:0] START      = 10'b00_0000_0010;
    localparam logic [9:0] CTRL_WRITE = 10'b00_0000_0100;
    localparam logic [9:0] ADDR_WRITE = 10'b00_0000_1000;
    localparam logic [9:0] DATA_WRITE = 10'b00_0001_0000;
    localparam logic [9:0] RESTART    = 10'b00_0010_0000;
    localparam logic [9:0] CTRL_READ  = 10'b00_0100_0000;
    localparam logic [9:0] DATA_READ  = 10'b00_1000_0000;
    localparam logic [9:0] STOP       = 10'b01_0000_0000;
    localparam logic [9:0] DONE       = 10'b10_0000_0000;

    logic [9:0]  state;
    eeprom_req_t req;
    logic        rd_phase; // set after the repeated start of a read
    logic [7:0]  ctrl_byte;

    assign ctrl_byte = {DEV_CODE, req.addr[ADDR_W-1:8], rd_phase};

    // byte for byte_tx, valid in the tx_load cycle
    always_comb
    begin
        case (state)
            ADDR_WRITE: tx_byte = req.addr[7:0];
            DATA_WRITE: tx_byte = req.wdata;
            default:    tx_byte = ctrl_byte;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
            req <= '{is_wr: wr, addr: addr, wdata: wdata}; // wr wins over rd
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            scl_run   <= 1'b0;
            tx_load   <= 1'b0;
            rx_start  <= 1'b0;
            rx_last   <= 1'b0;
            seq_drive <= '0;
            rd_phase  <= 1'b0;
            rdata     <= 8'h00;
            ack       <= 1'b0;
            nack_err  <= 1'b0;
            busy      <= 1'b0;
        end
        else
        begin
            tx_load  <= 1'b0;
            rx_start <= 1'b0;
            ack      <= 1'b0;
            case (state)
                IDLE:
                    if (wr || rd)
                    begin
                        busy      <= 1'b1;
                        nack_err  <= 1'b0;
                        rd_phase  <= 1'b0;
                        scl_run   <= 1'b1;
                        seq_drive <= '{sda_low: 1'b1, sda_en: 1'b1}; // start, SCL still high
                        state     <= START;
                    end
                START:
                    if (phase.scl_fall)
                    begin
                        tx_load   <= 1'b1;
                        seq_drive <= '0;
                        state     <= rd_phase ? CTRL_READ : CTRL_WRITE;
                    end
                CTRL_WRITE:
                    if (tx_done)
                    begin
                        if (tx_nack)
                        begin
                            nack_err <= 1'b1;
                            state    <= STOP;
                        end
                        else
                        begin
                            tx_load <= 1'b1;
                            state   <= ADDR_WRITE;
                        end
                    end
                ADDR_WRITE:
                    if (tx_done)
                    begin
                        if (tx_nack)
                        begin
                            nack_err <= 1'b1;
                            state    <= STOP;
                        end
                        else if (req.is_wr)
                        begin
                            tx_load <= 1'b1;
                            state   <= DATA_WRITE;
                        end
                        else
                            state <= RESTART;
                    end
                DATA_WRITE:
                    if (tx_done)
                    begin
                        nack_err <= tx_nack;
                        state    <= STOP;
                    end
                RESTART:
                    if (phase.scl_fall)
                        seq_drive <= '{sda_low: 1'b0, sda_en: 1'b1}; // let SDA go high first
                    else if (phase.high_mid && seq_drive.sda_en)
                    begin
                        seq_drive <= '{sda_low: 1'b1, sda_en: 1'b1};
                        rd_phase  <= 1'b1;
                        state     <= START;
                    end
                CTRL_READ:
                    if (tx_done)
                    begin
                        if (tx_nack)
                        begin
                            nack_err <= 1'b1;
                            state    <= STOP;
                        end
                        else
                        begin
                            rx_start <= 1'b1;
                            rx_last  <= 1'b1; // single byte read, always nack
                            state    <= DATA_READ;
                        end
                    end
                DATA_READ:
                    if (rx_done)
                    begin
                        rdata <= rx_byte;
                        state <= STOP;
                    end
                STOP:
                    if (phase.scl_fall)
                        seq_drive <= '{sda_low: 1'b1, sda_en: 1'b1};
                    else if (phase.high_mid && seq_drive.sda_en)
                    begin
                        seq_drive <= '0; // SDA rises with SCL high
                        scl_run   <= 1'b0;
                        state     <= DONE;
                    end
                DONE:
                begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/eeprom_master_top.sv
`timescale 1ns/1ps
module eeprom_master_top
    import eeprom_pkg::*;
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 2
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata,
    output logic              ack,
    output logic              nack_err,
    output logic              busy,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    i2c_phase_t phase;
    i2c_drive_t seq_drive;
    i2c_drive_t tx_drive;
    i2c_drive_t rx_drive;
    logic       scl_run;
    logic       tx_load;
    logic [7:0] tx_byte;
    logic       tx_done;
    logic       tx_nack;
    logic       rx_start;
    logic       rx_last;
    logic       rx_done;
    logic [7:0] rx_byte;

    // open-drain merge, one owner at a time
    assign sda_oe = (seq_drive.sda_en & seq_drive.sda_low)
                  | (tx_drive.sda_en & tx_drive.sda_low)
                  | (rx_drive.sda_en & rx_drive.sda_low);

    eeprom_seq i_eeprom_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .phase     (phase),
        .tx_done   (tx_done),
        .tx_nack   (tx_nack),
        .rx_done   (rx_done),
        .rx_byte   (rx_byte),
        .scl_run   (scl_run),
        .tx_load   (tx_load),
        .tx_byte   (tx_byte),
        .rx_start  (rx_start),
        .rx_last   (rx_last),
        .seq_drive (seq_drive),
        .rdata     (rdata),
        .ack       (ack),
        .nack_err  (nack_err),
        .busy      (busy)
    );

    scl_gen #(
        .CLK_DIV (CLK_DIV)
    ) i_scl_gen (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl_run (scl_run),
        .scl     (scl),
        .phase   (phase)
    );

    byte_tx i_byte_tx (
        .CLK      (CLK),
        .RESET    (RESET),
        .phase    (phase),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .sda_in   (sda_in),
        .tx_drive (tx_drive),
        .tx_done  (tx_done),
        .tx_nack  (tx_nack)
    );

    byte_rx i_byte_rx (
        .CLK      (CLK),
        .RESET    (RESET),
        .phase    (phase),
        .rx_start (rx_start),
        .rx_last  (rx_last),
        .sda_in   (sda_in),
        .rx_drive (rx_drive),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte)
    );

endmodule

//--- tb/tb_clk.sv
`timescale 1ns/1ps
module tb_clk
(
    output logic CLK
);

    initial
    begin
        CLK = 1'b0;
    end

    always #10 CLK = ~CLK; // 20 ns period

endmodule

//--- tb/eeprom_slave_model.sv
`timescale 1ns/1ps
module eeprom_slave_model
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              scl,
    input  logic              sda,
    input  logic              refuse,   // no ack for any byte
    input  logic [ADDR_W-1:0] exp_addr, // address of the current host request
    output logic              sda_pull,
    output logic              proto_err,
    output int                xfer_count,
    output int                write_count
);

    logic [7:0]        mem [0:2047];
    logic              scl_q;
    logic              sda_q;
    logic              in_xfer;
    logic              restarted;
    logic              have_ptr;
    logic              bytes_done;
    logic              ack_pending;
    logic              in_ack;
    logic              start_send;
    logic              sending;
    logic              expect_stop;
    logic [3:0]        rcnt; // SCL rises in the current byte, 9 with ack
    logic [3:0]        new_r;
    logic [3:0]        scnt;
    logic [2:0]        byte_idx; // 0 ctrl, 1 addr, 2 data, 3 extra, 4 read data, 5 read nack
    logic [7:0]        shreg;
    logic [7:0]        cur_byte;
    logic [7:0]        send_byte;
    logic [ADDR_W-1:0] ptr;
    logic              rise;
    logic              fall;
    logic              start_c;
    logic              stop_c;

    assign rise     = !scl_q && scl;
    assign fall     = scl_q && !scl;
    assign start_c  = scl_q && scl && sda_q && !sda;
    assign stop_c   = scl_q && scl && !sda_q && sda;
    assign new_r    = (rcnt == 4'd9) ? 4'd1 : rcnt + 4'd1;
    assign cur_byte = {shreg[6:0], sda};

    function automatic logic [7:0] fill_byte(input int i);
        logic [10:0] a;
        a = i[10:0];
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = fill_byte(i);
    end

    task automatic flag(input string msg);
        $display("protocol violation at %0t: %s", $time, msg);
        proto_err <= 1'b1;
    endtask

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            in_xfer     <= 1'b0;
            restarted   <= 1'b0;
            have_ptr    <= 1'b0;
            bytes_done  <= 1'b0;
            ack_pending <= 1'b0;
            in_ack      <= 1'b0;
            start_send  <= 1'b0;
            sending     <= 1'b0;
            expect_stop <= 1'b0;
            rcnt        <= 4'd0;
            scnt        <= 4'd0;
            byte_idx    <= 3'd0;
            sda_pull    <= 1'b0;
            proto_err   <= 1'b0;
            xfer_count  <= 0;
            write_count <= 0;
        end
        else if (start_c)
        begin
            if (in_xfer && !(rcnt == 4'd1 && bytes_done))
                flag("start condition in the middle of a byte");
            if (in_xfer && !have_ptr)
                flag("repeated start before the word address");
            if (!in_xfer)
                have_ptr <= 1'b0;
            restarted   <= in_xfer;
            in_xfer     <= 1'b1;
            rcnt        <= 4'd0;
            byte_idx    <= 3'd0;
            bytes_done  <= 1'b0;
            ack_pending <= 1'b0;
            in_ack      <= 1'b0;
            sending     <= 1'b0;
            expect_stop <= 1'b0;
            sda_pull    <= 1'b0;
        end
        else if (stop_c)
        begin
            if (!in_xfer)
                flag("stop condition outside a transaction");
            else if (!(rcnt == 4'd1 && bytes_done))
                flag("stop condition in the middle of a byte");
            in_xfer     <= 1'b0;
            xfer_count  <= xfer_count + 1;
            sda_pull    <= 1'b0;
            sending     <= 1'b0;
            expect_stop <= 1'b0;
        end
        else if (rise)
        begin
            if (!in_xfer)
                flag("SCL pulse without a start condition");
            else
            begin
                rcnt <= new_r;
                if (expect_stop && rcnt == 4'd1)
                    flag("read data byte not followed by a stop");
                if (new_r <= 4'd8)
                    shreg <= cur_byte;
                if (new_r == 4'd8)
                begin
                    bytes_done <= 1'b1;
                    case (byte_idx)
                        3'd0:
                        begin
                            if (cur_byte[7:4] != DEV_CODE)
                                flag("control byte has a wrong device code");
                            if (cur_byte[3:1] != exp_addr[ADDR_W-1:8])
                                flag("control byte has wrong block address bits");
                            if (cur_byte[0] != restarted)
                                flag("control byte has a wrong read/write bit");
                            ack_pending <= !refuse && cur_byte[7:4] == DEV_CODE;
                            start_send  <= !refuse && cur_byte[0];
                            send_byte   <= mem[ptr];
                            ptr[ADDR_W-1:8] <= cur_byte[3:1];
                            byte_idx    <= cur_byte[0] ? 3'd4 : 3'd1;
                        end
                        3'd1:
                        begin
                            if (cur_byte != exp_addr[7:0])
                                flag("word address byte does not match the request");
                            ptr[7:0]    <= cur_byte;
                            have_ptr    <= 1'b1;
                            ack_pending <= !refuse;
                            byte_idx    <= 3'd2;
                        end
                        3'd2:
                        begin
                            mem[ptr]    <= cur_byte;
                            write_count <= write_count + 1;
                            ack_pending <= !refuse;
                            byte_idx    <= 3'd3;
                        end
                        3'd4:
                            byte_idx <= 3'd5; // data byte sent, master's nack slot next
                        default:
                            flag("extra byte after the data byte");
                    endcase
                end
                if (new_r == 4'd9 && byte_idx == 3'd5)
                begin
                    if (sda != 1'b1)
                        flag("read data byte acknowledged by the master");
                    expect_stop <= 1'b1;
                end
            end
        end
        else if (fall)
        begin
            if (!in_xfer)
                flag("SCL falls outside a transaction");
            if (ack_pending)
            begin
                sda_pull    <= 1'b1;
                ack_pending <= 1'b0;
                in_ack      <= 1'b1;
            end
            else if (in_ack)
            begin
                in_ack <= 1'b0;
                if (start_send)
                begin
                    start_send <= 1'b0;
                    sending    <= 1'b1;
                    sda_pull   <= ~send_byte[7];
                    send_byte  <= {send_byte[6:0], 1'b0};
                    scnt       <= 4'd1;
                end
                else
                    sda_pull <= 1'b0;
            end
            else if (sending)
            begin
                if (scnt < 4'd8)
                begin
                    sda_pull  <= ~send_byte[7];
                    send_byte <= {send_byte[6:0], 1'b0};
                    scnt      <= scnt + 4'd1;
                end
                else
                begin
                    sda_pull <= 1'b0; // master's ack slot
                    sending  <= 1'b0;
                end
            end
        end
    end

endmodule

//--- tb/tb_eeprom_master.sv
`timescale 1ns/1ps
module tb_eeprom_master
    import eeprom_pkg::*;
();

    localparam int CLK_DIV = 2;
    localparam int N_PAIRS = 20;
    localparam int N_OPS   = 2 * N_PAIRS + 2;
    localparam int TIMEOUT = N_OPS * 4 * CLK_DIV * 60;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic [7:0]        rdata;
    logic              ack;
    logic              nack_err;
    logic              busy;
    logic              scl;
    logic              sda_oe;
    logic              sda_in;
    logic              sda_pull;
    logic              refuse;
    logic [ADDR_W-1:0] exp_addr;
    logic              proto_err;
    int                xfer_count;
    int                write_count;
    logic [7:0]        ref_mem [0:2047];
    int                seed;
    int                ack_count;
    int                cycle_count;
    int                ops_done;

    assign sda_in = ~(sda_oe | sda_pull); // wired-AND bus

    tb_clk i_tb_clk (.CLK(CLK));

    eeprom_master_top #(.CLK_DIV(CLK_DIV)) i_eeprom_master_top (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .nack_err(nack_err), .busy(busy),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    eeprom_slave_model i_slave (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda_in), .refuse(refuse),
        .exp_addr(exp_addr), .sda_pull(sda_pull), .proto_err(proto_err),
        .xfer_count(xfer_count), .write_count(write_count)
    );

    function automatic logic [7:0] init_pattern(input int i);
        logic [10:0] a;
        a = i[10:0];
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            $display("ERROR %0t: %s expected %0h, got %0h", $time, what, expected, actual);
            abort_run();
        end
    endtask

    // one host request, with a stray strobe thrown in while busy
    task automatic run_op(input logic is_wr, input logic [10:0] a, input logic [7:0] d,
                          input logic exp_nack);
        int          k;
        int          pulse_at;
        logic [31:0] r;
        r        = $random(seed);
        pulse_at = 3 + int'(r[4:0]);
        wr       <= is_wr;
        rd       <= !is_wr;
        addr     <= a;
        wdata    <= d;
        exp_addr <= a;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        @(posedge CLK);
        check_val("busy after accepted strobe", 1, 32'(busy));
        k = 2;
        while (!ack)
        begin
            if (k == pulse_at)
            begin
                r     = $random(seed);
                wr    <= r[0];
                rd    <= !r[0];
                addr  <= r[21:11];
                wdata <= r[31:24];
            end
            else
            begin
                wr <= 1'b0;
                rd <= 1'b0;
            end
            @(posedge CLK);
            k++;
        end
        check_val("busy in ack cycle", 0, 32'(busy));
        check_val("nack_err", 32'(exp_nack), 32'(nack_err));
        if (!is_wr)
            check_val("rdata", 32'(ref_mem[a]), 32'(rdata));
        ops_done++;
        @(posedge CLK);
        check_val("busy after ack", 0, 32'(busy));
        check_val("ack length", 0, 32'(ack));
        check_val("scl at idle", 1, 32'(scl));
        check_val("sda_oe at idle", 0, 32'(sda_oe));
        check_val("ack count", 32'(ops_done), 32'(ack_count));
        check_val("bus transaction count", 32'(ops_done), 32'(xfer_count));
    endtask

    always @(posedge CLK)
    begin
        if (ack)
            ack_count <= ack_count + 1;
    end

    always @(posedge CLK)
    begin
        assert (!proto_err)
        else
        begin
            $display("ERROR %0t: slave model reported a bus protocol violation", $time);
            abort_run();
        end
    end

    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT)
        begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [10:0] a;
        logic [7:0]  d;
        int          writes;
        seed        = 32'hd4704231;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        refuse      = 1'b0;
        exp_addr    = '0;
        ack_count   = 0;
        cycle_count = 0;
        ops_done    = 0;
        writes      = 0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = init_pattern(i);
        repeat (8) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        check_val("scl after reset", 1, 32'(scl));
        check_val("sda_oe after reset", 0, 32'(sda_oe));
        check_val("busy after reset", 0, 32'(busy));
        check_val("ack after reset", 0, 32'(ack));
        check_val("rdata after reset", 0, 32'(rdata));

        for (int i = 0; i < N_PAIRS; i++)
        begin
            r = $random(seed);
            a = r[10:0];
            d = r[18:11];
            run_op(1'b1, a, d, 1'b0);
            ref_mem[a] = d;
            writes++;
            run_op(1'b0, a, 8'h00, 1'b0);
        end
        check_val("memory writes", 32'(writes), 32'(write_count));

        // refused write must leave memory alone
        r = $random(seed);
        a = r[10:0];
        d = ~ref_mem[a];
        refuse <= 1'b1;
        run_op(1'b1, a, d, 1'b1);
        refuse <= 1'b0;
        run_op(1'b0, a, 8'h00, 1'b0);
        check_val("memory writes", 32'(writes), 32'(write_count));

        if (proto_err)
            abort_run();
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

//--- build.f
common/eeprom_pkg.sv
common/i2c_pkg.sv
hdl/scl_gen.sv
hdl/byte_tx.sv
hdl/byte_rx.sv
eeprom_ctrl/eeprom_seq.sv
hdl/eeprom_master_top.sv
tb/tb_clk.sv
tb/eeprom_slave_model.sv
tb/tb_eeprom_master.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the EEPROM master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_eeprom_master -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    echo "failure found in sim.log"
    exit 1
fi

exit 0
